//--- design/fetch_decode_pkg.sv
// Shared definitions for the dual-issue decode stage
// Holds the bundle and slot types, the decode class flags and the
// RV32 major opcode values used by the instruction classifier

package fetch_decode_pkg;

    // ------------------------------------------------------------------------
    // Basic types
    // ------------------------------------------------------------------------
    typedef logic [31:0] pc_t;
    typedef logic [31:0] instr_t;

    // Slot 0 in the low half, slot 1 in the high half
    typedef logic [63:0] bundle_t;

    // Class flags produced per slot, MSB first
    typedef struct packed {
        logic invalid;
        logic exec;
        logic lsu;
        logic branch;
        logic mul;
        logic div;
        logic csr;
        logic rd_valid;
    } decode_info_t;

    // ------------------------------------------------------------------------
    // RV32 major opcodes
    // ------------------------------------------------------------------------
    localparam logic [6:0] OPC_LUI      = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
    localparam logic [6:0] OPC_JAL      = 7'b1101111;
    localparam logic [6:0] OPC_JALR     = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
    localparam logic [6:0] OPC_LOAD     = 7'b0000011;
    localparam logic [6:0] OPC_STORE    = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
    localparam logic [6:0] OPC_OP       = 7'b0110011;
    localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

    // funct7 of the M extension (MUL/DIV/REM family)
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    // Low PC bits of the second instruction in a bundle
    localparam logic [2:0] SLOT1_PC_OFFSET = 3'd4;

endpackage

//--- design/issue_slot_if.sv
// Issue slot bundle
// Carries one instruction with its PC and fault flags from the
// bundle queue head to the decoder of that slot

interface issue_slot_if;

    logic                     valid;
    fetch_decode_pkg::instr_t instr;
    fetch_decode_pkg::pc_t    pc;
    logic                     fault_fetch;
    logic                     fault_page;

    // Queue side drives the head entry
    modport queue
    (
        output valid,
        output instr,
        output pc,
        output fault_fetch,
        output fault_page
    );

    // Decoder side only observes
    modport decode
    (
        input valid,
        input instr,
        input pc,
        input fault_fetch,
        input fault_page
    );

endinterface

//--- design/fetch_fifo.sv
// Fetch bundle queue
// Circular buffer of two-instruction bundles; each entry keeps a valid
// bit per slot so the slots can be issued separately. The head entry
// retires once both of its slots are gone. Flush empties the queue.

module fetch_fifo
#(
    parameter int FIFO_DEPTH = 2
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,
    input  logic                      flush_i,

    // Fetch side
    input  logic                      push_i,
    input  fetch_decode_pkg::pc_t     pc_i,
    input  logic                      pred_branch_i,
    input  fetch_decode_pkg::bundle_t bundle_i,
    input  logic                      fault_fetch_i,
    input  logic                      fault_page_i,
    output logic                      accept_o,

    // Issue side
    input  logic                      pop0_i,
    input  logic                      pop1_i,
    issue_slot_if.queue               slot0_o,
    issue_slot_if.queue               slot1_o
);

    localparam int ADDR_W  = $clog2(FIFO_DEPTH);
    localparam int COUNT_W = ADDR_W + 1;

    // ------------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------------
    fetch_decode_pkg::bundle_t bundle_q [FIFO_DEPTH];
    fetch_decode_pkg::pc_t     pc_q     [FIFO_DEPTH];
    logic [FIFO_DEPTH-1:0]     fault_fetch_q;
    logic [FIFO_DEPTH-1:0]     fault_page_q;

    // Per-entry slot valids and pointers
    logic [FIFO_DEPTH-1:0]     slot0_valid_q;
    logic [FIFO_DEPTH-1:0]     slot1_valid_q;
    logic [ADDR_W-1:0]         rd_ptr_q;
    logic [ADDR_W-1:0]         wr_ptr_q;
    logic [COUNT_W-1:0]        count_q;

    fetch_decode_pkg::bundle_t bundle_w;
    logic                      not_empty_w;
    logic                      head_valid0_w;
    logic                      head_valid1_w;
    logic                      push_w;
    logic                      pop0_w;
    logic                      pop1_w;
    logic                      retire_w;

    // Faulted fetches carry no usable instructions
    assign bundle_w = (fault_fetch_i | fault_page_i) ? '0 : bundle_i;

    assign not_empty_w   = (count_q != '0);
    assign head_valid0_w = not_empty_w & slot0_valid_q[rd_ptr_q];
    assign head_valid1_w = not_empty_w & slot1_valid_q[rd_ptr_q];

    assign accept_o = (count_q != COUNT_W'(FIFO_DEPTH));
    assign push_w   = push_i & accept_o;
    assign pop0_w   = pop0_i & head_valid0_w;
    assign pop1_w   = pop1_i & head_valid1_w;

    // Last remaining slot of the head goes, alone or with its partner
    assign retire_w = (pop0_w & ~head_valid1_w) |
                      (pop1_w & ~head_valid0_w) |
                      (pop0_w & pop1_w);

    // ------------------------------------------------------------------------
    // Payload write
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (push_w)
        begin
            bundle_q[wr_ptr_q]      <= bundle_w;
            pc_q[wr_ptr_q]          <= pc_i;
            fault_fetch_q[wr_ptr_q] <= fault_fetch_i;
            fault_page_q[wr_ptr_q]  <= fault_page_i;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, count and slot valids
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or posedge rst_i)
    begin
        if (rst_i)
        begin
            rd_ptr_q      <= '0;
            wr_ptr_q      <= '0;
            count_q       <= '0;
            slot0_valid_q <= '0;
            slot1_valid_q <= '0;
        end
        else if (flush_i)
        begin
            rd_ptr_q      <= '0;
            wr_ptr_q      <= '0;
            count_q       <= '0;
            slot0_valid_q <= '0;
            slot1_valid_q <= '0;
        end
        else
        begin
            if (push_w)
            begin
                slot0_valid_q[wr_ptr_q] <= 1'b1;
                // Predicted-taken branch in slot 0 kills slot 1
                slot1_valid_q[wr_ptr_q] <= ~pred_branch_i;
                wr_ptr_q                <= wr_ptr_q + 1'b1;
            end

            if (pop0_w)
                slot0_valid_q[rd_ptr_q] <= 1'b0;
            if (pop1_w)
                slot1_valid_q[rd_ptr_q] <= 1'b0;

            if (retire_w)
                rd_ptr_q <= rd_ptr_q + 1'b1;

            if (push_w & ~retire_w)
                count_q <= count_q + 1'b1;
            else if (~push_w & retire_w)
                count_q <= count_q - 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Head entry to the issue slots
    // ------------------------------------------------------------------------
    assign slot0_o.valid       = head_valid0_w;
    assign slot0_o.instr       = bundle_q[rd_ptr_q][31:0];
    assign slot0_o.pc          = {pc_q[rd_ptr_q][31:3], 3'b000};
    assign slot0_o.fault_fetch = fault_fetch_q[rd_ptr_q];
    assign slot0_o.fault_page  = fault_page_q[rd_ptr_q];

    assign slot1_o.valid       = head_valid1_w;
    assign slot1_o.instr       = bundle_q[rd_ptr_q][63:32];
    assign slot1_o.pc          = {pc_q[rd_ptr_q][31:3], fetch_decode_pkg::SLOT1_PC_OFFSET};
    assign slot1_o.fault_fetch = fault_fetch_q[rd_ptr_q];
    assign slot1_o.fault_page  = fault_page_q[rd_ptr_q];

endmodule

//--- design/instr_decoder.sv
// RV32IM instruction classifier
// Purely combinational; sorts one issue slot into execution classes
// and flags whether the instruction writes a destination register

module instr_decoder
#(
    parameter bit SUPPORT_MULDIV = 1'b1
)
(
    issue_slot_if.decode                 slot_i,
    output fetch_decode_pkg::decode_info_t info_o
);

    // Instruction fields
    logic [6:0] opcode_w;
    logic [4:0] rd_w;
    logic [2:0] funct3_w;
    logic [6:0] funct7_w;

    // Slot is decodable
    logic       live_w;

    logic       is_m_w;
    logic       is_lsu_w;
    logic       is_branch_w;
    logic       is_exec_w;
    logic       is_mul_w;
    logic       is_div_w;
    logic       is_csr_w;
    logic       writes_rd_w;

    assign opcode_w = slot_i.instr[6:0];
    assign rd_w     = slot_i.instr[11:7];
    assign funct3_w = slot_i.instr[14:12];
    assign funct7_w = slot_i.instr[31:25];

    assign live_w = slot_i.valid & ~slot_i.fault_fetch & ~slot_i.fault_page;

    // ------------------------------------------------------------------------
    // Class detection
    // ------------------------------------------------------------------------
    assign is_m_w = (opcode_w == fetch_decode_pkg::OPC_OP) &&
                    (funct7_w == fetch_decode_pkg::FUNCT7_MULDIV);

    assign is_lsu_w = (opcode_w == fetch_decode_pkg::OPC_LOAD) ||
                      (opcode_w == fetch_decode_pkg::OPC_STORE);

    assign is_branch_w = (opcode_w == fetch_decode_pkg::OPC_JAL)  ||
                         (opcode_w == fetch_decode_pkg::OPC_JALR) ||
                         (opcode_w == fetch_decode_pkg::OPC_BRANCH);

    assign is_exec_w = (opcode_w == fetch_decode_pkg::OPC_LUI)    ||
                       (opcode_w == fetch_decode_pkg::OPC_AUIPC)  ||
                       (opcode_w == fetch_decode_pkg::OPC_OP_IMM) ||
                       ((opcode_w == fetch_decode_pkg::OPC_OP) && !is_m_w);

    // funct3 bit 2 splits MUL* from DIV*/REM*
    assign is_mul_w = SUPPORT_MULDIV && is_m_w && !funct3_w[2];
    assign is_div_w = SUPPORT_MULDIV && is_m_w && funct3_w[2];

    // Fences go down the CSR path too
    assign is_csr_w = (opcode_w == fetch_decode_pkg::OPC_SYSTEM) ||
                      (opcode_w == fetch_decode_pkg::OPC_MISC_MEM);

    // CSR reads write rd; ECALL/EBREAK/xRET have funct3 of zero
    assign writes_rd_w = is_exec_w || is_mul_w || is_div_w                    ||
                         (opcode_w == fetch_decode_pkg::OPC_LOAD)             ||
                         (opcode_w == fetch_decode_pkg::OPC_JAL)              ||
                         (opcode_w == fetch_decode_pkg::OPC_JALR)             ||
                         ((opcode_w == fetch_decode_pkg::OPC_SYSTEM) && (funct3_w != 3'b000));

    // ------------------------------------------------------------------------
    // Flag output
    // ------------------------------------------------------------------------
    always_comb
    begin
        info_o = '0;
        if (live_w)
        begin
            info_o.exec     = is_exec_w;
            info_o.lsu      = is_lsu_w;
            info_o.branch   = is_branch_w;
            info_o.mul      = is_mul_w;
            info_o.div      = is_div_w;
            info_o.csr      = is_csr_w;
            // Unknown opcode, or M op with the unit absent
            info_o.invalid  = !(is_exec_w || is_lsu_w || is_branch_w ||
                                is_mul_w  || is_div_w || is_csr_w);
            info_o.rd_valid = (rd_w != 5'd0) && writes_rd_w;
        end
    end

endmodule

//--- design/fetch_decode.sv
// Dual-issue decode stage
// Queues fetch bundles and presents the head entry as two issue slots,
// each classified by its own RV32IM decoder in the same cycle

module fetch_decode
#(
    parameter bit SUPPORT_MULDIV = 1'b1,
    parameter int FIFO_DEPTH     = 2
)
(
    input  logic                      clk_i,
    input  logic                      rst_i,

    // Fetch unit
    input  logic                      fetch_valid_i,
    input  fetch_decode_pkg::bundle_t fetch_instr_i,
    input  fetch_decode_pkg::pc_t     fetch_pc_i,
    input  logic                      fetch_pred_branch_i,
    input  logic                      fetch_fault_fetch_i,
    input  logic                      fetch_fault_page_i,
    output logic                      fetch_accept_o,

    input  logic                      slot0_accept_i,
    input  logic                      slot1_accept_i,
    input  logic                      branch_request_i,

    // Issue slot 0
    output logic                      slot0_valid_o,
    output fetch_decode_pkg::instr_t  slot0_instr_o,
    output fetch_decode_pkg::pc_t     slot0_pc_o,
    output logic                      slot0_fault_fetch_o,
    output logic                      slot0_fault_page_o,
    output logic                      slot0_invalid_o,
    output logic                      slot0_exec_o,
    output logic                      slot0_lsu_o,
    output logic                      slot0_branch_o,
    output logic                      slot0_mul_o,
    output logic                      slot0_div_o,
    output logic                      slot0_csr_o,
    output logic                      slot0_rd_valid_o,

    // Issue slot 1
    output logic                      slot1_valid_o,
    output fetch_decode_pkg::instr_t  slot1_instr_o,
    output fetch_decode_pkg::pc_t     slot1_pc_o,
    output logic                      slot1_fault_fetch_o,
    output logic                      slot1_fault_page_o,
    output logic                      slot1_invalid_o,
    output logic                      slot1_exec_o,
    output logic                      slot1_lsu_o,
    output logic                      slot1_branch_o,
    output logic                      slot1_mul_o,
    output logic                      slot1_div_o,
    output logic                      slot1_csr_o,
    output logic                      slot1_rd_valid_o
);

    issue_slot_if slot0_if ();
    issue_slot_if slot1_if ();

    fetch_decode_pkg::decode_info_t info0_w;
    fetch_decode_pkg::decode_info_t info1_w;

    // ------------------------------------------------------------------------
    // Bundle queue, flushed by a taken branch
    // ------------------------------------------------------------------------
    fetch_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .flush_i       (branch_request_i),
        .push_i        (fetch_valid_i),
        .pc_i          (fetch_pc_i),
        .pred_branch_i (fetch_pred_branch_i),
        .bundle_i      (fetch_instr_i),
        .fault_fetch_i (fetch_fault_fetch_i),
        .fault_page_i  (fetch_fault_page_i),
        .accept_o      (fetch_accept_o),
        .pop0_i        (slot0_accept_i),
        .pop1_i        (slot1_accept_i),
        .slot0_o       (slot0_if),
        .slot1_o       (slot1_if)
    );

    // ------------------------------------------------------------------------
    // One classifier per slot
    // ------------------------------------------------------------------------
    instr_decoder #(
        .SUPPORT_MULDIV (SUPPORT_MULDIV)
    ) u_dec0 (
        .slot_i (slot0_if),
        .info_o (info0_w)
    );

    instr_decoder #(
        .SUPPORT_MULDIV (SUPPORT_MULDIV)
    ) u_dec1 (
        .slot_i (slot1_if),
        .info_o (info1_w)
    );

    // Slot 0 outputs
    assign slot0_valid_o       = slot0_if.valid;
    assign slot0_instr_o       = slot0_if.instr;
    assign slot0_pc_o          = slot0_if.pc;
    assign slot0_fault_fetch_o = slot0_if.fault_fetch;
    assign slot0_fault_page_o  = slot0_if.fault_page;
    assign slot0_invalid_o     = info0_w.invalid;
    assign slot0_exec_o        = info0_w.exec;
    assign slot0_lsu_o         = info0_w.lsu;
    assign slot0_branch_o      = info0_w.branch;
    assign slot0_mul_o         = info0_w.mul;
    assign slot0_div_o         = info0_w.div;
    assign slot0_csr_o         = info0_w.csr;
    assign slot0_rd_valid_o    = info0_w.rd_valid;

    // Slot 1 outputs
    assign slot1_valid_o       = slot1_if.valid;
    assign slot1_instr_o       = slot1_if.instr;
    assign slot1_pc_o          = slot1_if.pc;
    assign slot1_fault_fetch_o = slot1_if.fault_fetch;
    assign slot1_fault_page_o  = slot1_if.fault_page;
    assign slot1_invalid_o     = info1_w.invalid;
    assign slot1_exec_o        = info1_w.exec;
    assign slot1_lsu_o         = info1_w.lsu;
    assign slot1_branch_o      = info1_w.branch;
    assign slot1_mul_o         = info1_w.mul;
    assign slot1_div_o         = info1_w.div;
    assign slot1_csr_o         = info1_w.csr;
    assign slot1_rd_valid_o    = info1_w.rd_valid;

endmodule

//--- verification/decode_ref.svh
// Reference RV32IM class decode for the decode stage testbench
// Predicts the eight class flags of one issue slot from its instruction

`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic fetch_decode_pkg::decode_info_t decode_ref(
    input fetch_decode_pkg::instr_t instr,
    input logic                     live,
    input bit                       muldiv_en
);
    fetch_decode_pkg::decode_info_t info;
    logic                           writes;
    logic                           m_op;

    info   = '0;
    writes = 1'b0;
    m_op   = (instr[31:25] == fetch_decode_pkg::FUNCT7_MULDIV);

    case (instr[6:0])
        fetch_decode_pkg::OPC_LUI,
        fetch_decode_pkg::OPC_AUIPC,
        fetch_decode_pkg::OPC_OP_IMM:   {info.exec, writes} = 2'b11;
        fetch_decode_pkg::OPC_OP:
            if (!m_op)
                {info.exec, writes} = 2'b11;
            else if (!muldiv_en)
                info.invalid = 1'b1;
            else if (instr[14:12] < 3'd4)
                {info.mul, writes} = 2'b11;
            else
                {info.div, writes} = 2'b11;
        fetch_decode_pkg::OPC_LOAD:     {info.lsu, writes} = 2'b11;
        fetch_decode_pkg::OPC_STORE:    info.lsu = 1'b1;
        fetch_decode_pkg::OPC_JAL,
        fetch_decode_pkg::OPC_JALR:     {info.branch, writes} = 2'b11;
        fetch_decode_pkg::OPC_BRANCH:   info.branch = 1'b1;
        // ECALL and EBREAK have funct3 of zero and write no register
        fetch_decode_pkg::OPC_SYSTEM:   {info.csr, writes} = {1'b1, instr[14:12] != 3'b000};
        fetch_decode_pkg::OPC_MISC_MEM: info.csr = 1'b1;
        default:                        info.invalid = 1'b1;
    endcase

    info.rd_valid = writes && (instr[11:7] != 5'd0);

    // Empty or faulted slots show no class at all
    return live ? info : '0;
endfunction

`endif

//--- verification/fetch_decode_tb.sv
// Testbench for the dual-issue decode stage
// Random bundles under back-pressure, flushes, predicted branches and
// faults; a queue model predicts every slot output of the head entry

module fetch_decode_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int FIFO_DEPTH     = 2;
    localparam bit SUPPORT_MULDIV = 1'b1;
    localparam int N_BUNDLES      = 600;
    // About 3 cycles per bundle at half accept rate plus stalls, with margin
    localparam int TIMEOUT_CYCLES = 4000;

    // One expected issue slot
    typedef struct packed {
        fetch_decode_pkg::instr_t       instr;
        fetch_decode_pkg::pc_t          pc;
        logic                           fault_fetch;
        logic                           fault_page;
        logic                           valid;
        fetch_decode_pkg::decode_info_t info;
    } slot_rec_t;

    logic                      clk_i = 1'b0;
    logic                      rst_i;
    logic                      fetch_valid_i;
    fetch_decode_pkg::bundle_t fetch_instr_i;
    fetch_decode_pkg::pc_t     fetch_pc_i;
    logic                      fetch_pred_branch_i;
    logic                      fetch_fault_fetch_i;
    logic                      fetch_fault_page_i;
    logic                      fetch_accept_o;
    logic                      slot0_accept_i;
    logic                      slot1_accept_i;
    logic                      branch_request_i;
    fetch_decode_pkg::instr_t  slot0_instr_o;
    fetch_decode_pkg::instr_t  slot1_instr_o;
    fetch_decode_pkg::pc_t     slot0_pc_o;
    fetch_decode_pkg::pc_t     slot1_pc_o;
    // Per-slot status and class flags
    logic                      slot0_valid_o;
    logic                      slot0_fault_fetch_o;
    logic                      slot0_fault_page_o;
    logic                      slot1_valid_o;
    logic                      slot1_fault_fetch_o;
    logic                      slot1_fault_page_o;
    logic                      slot0_invalid_o;
    logic                      slot0_exec_o;
    logic                      slot0_lsu_o;
    logic                      slot0_branch_o;
    logic                      slot0_mul_o;
    logic                      slot0_div_o;
    logic                      slot0_csr_o;
    logic                      slot0_rd_valid_o;
    logic                      slot1_invalid_o;
    logic                      slot1_exec_o;
    logic                      slot1_lsu_o;
    logic                      slot1_branch_o;
    logic                      slot1_mul_o;
    logic                      slot1_div_o;
    logic                      slot1_csr_o;
    logic                      slot1_rd_valid_o;

    fetch_decode fetch_decode_inst (.*);

    `include "decode_ref.svh"

    // Pending bundles, one record per slot, head at index 0
    slot_rec_t exp0_q[$];
    slot_rec_t exp1_q[$];
    int        push_count   = 0;
    int        cycle_count  = 0;
    int        stall_left   = 0;
    logic      bundle_taken = 1'b1;

    always #20 clk_i = ~clk_i;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("FAIL %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_slot(input int n, input slot_rec_t dut, input slot_rec_t exp);
        string p;
        p = $sformatf("slot%0d_", n);
        assert (!dut.valid || exp.valid)
        else
            abort_run($sformatf("slot %0d is valid while nothing is expected there", n));
        assert (dut.valid || !exp.valid)
        else
            abort_run($sformatf("expected valid slot %0d is missing", n));
        if (dut.valid)
        begin
            compare_value({p, "instr_o"}, dut.instr, exp.instr);
            compare_value({p, "pc_o"}, dut.pc, exp.pc);
            compare_value({p, "fault_fetch_o"}, dut.fault_fetch, exp.fault_fetch);
            compare_value({p, "fault_page_o"}, dut.fault_page, exp.fault_page);
            compare_value({p, "invalid_o"}, dut.info.invalid, exp.info.invalid);
            compare_value({p, "exec_o"}, dut.info.exec, exp.info.exec);
            compare_value({p, "lsu_o"}, dut.info.lsu, exp.info.lsu);
            compare_value({p, "branch_o"}, dut.info.branch, exp.info.branch);
            compare_value({p, "mul_o"}, dut.info.mul, exp.info.mul);
            compare_value({p, "div_o"}, dut.info.div, exp.info.div);
            compare_value({p, "csr_o"}, dut.info.csr, exp.info.csr);
            compare_value({p, "rd_valid_o"}, dut.info.rd_valid, exp.info.rd_valid);
        end
    endtask

    // Expected slot for the bundle currently on the fetch inputs
    function automatic slot_rec_t expect_slot(input fetch_decode_pkg::instr_t instr,
                                              input logic [2:0] pc_low, input logic valid);
        slot_rec_t r;
        logic      fault;
        fault         = fetch_fault_fetch_i | fetch_fault_page_i;
        r.instr       = fault ? '0 : instr;
        r.pc          = {fetch_pc_i[31:3], pc_low};
        r.fault_fetch = fetch_fault_fetch_i;
        r.fault_page  = fetch_fault_page_i;
        r.valid       = valid;
        r.info        = decode_ref(r.instr, valid && !fault, SUPPORT_MULDIV);
        return r;
    endfunction

    // Random instruction from one of the opcode classes
    function automatic fetch_decode_pkg::instr_t make_instr();
        fetch_decode_pkg::instr_t w;
        w = $urandom;
        case ($urandom_range(12))
            0:  w[6:0] = fetch_decode_pkg::OPC_LUI;
            1:  w[6:0] = fetch_decode_pkg::OPC_AUIPC;
            2:  w[6:0] = fetch_decode_pkg::OPC_JAL;
            3:  w[6:0] = fetch_decode_pkg::OPC_JALR;
            4:  w[6:0] = fetch_decode_pkg::OPC_BRANCH;
            5:  w[6:0] = fetch_decode_pkg::OPC_LOAD;
            6:  w[6:0] = fetch_decode_pkg::OPC_STORE;
            7:  w[6:0] = fetch_decode_pkg::OPC_OP_IMM;
            8:  {w[31:25], w[6:0]} = {($urandom_range(1) ? 7'h20 : 7'h00),
                                      fetch_decode_pkg::OPC_OP};
            9:  {w[31:25], w[6:0]} = {fetch_decode_pkg::FUNCT7_MULDIV,
                                      fetch_decode_pkg::OPC_OP};
            10: w[6:0] = fetch_decode_pkg::OPC_MISC_MEM;
            11: w[6:0] = fetch_decode_pkg::OPC_SYSTEM;
            // Mostly unused opcodes
            default: w[6:0] = 7'($urandom);
        endcase
        if ($urandom_range(7) == 0)
            w[11:7] = 5'd0;
        return w;
    endfunction

    task automatic drive_random();
        // Fetch holds a bundle that was not taken
        if (bundle_taken)
        begin
            fetch_valid_i       = ($urandom_range(3) != 0);
            fetch_instr_i       = {make_instr(), make_instr()};
            fetch_pc_i          = $urandom;
            fetch_pred_branch_i = ($urandom_range(7) == 0);
            fetch_fault_fetch_i = ($urandom_range(15) == 0);
            fetch_fault_page_i  = ($urandom_range(15) == 0);
        end
        branch_request_i = ($urandom_range(47) == 0);
        if (stall_left == 0 && $urandom_range(99) == 0)
            stall_left = 8 + $urandom_range(12);
        if (stall_left != 0)
            stall_left--;
        slot0_accept_i = (stall_left == 0) && $urandom_range(1);
        slot1_accept_i = (stall_left == 0) && $urandom_range(1);
    endtask

    // ------------------------------------------------------------------------
    // Scoreboard checks the head entry at each edge and then advances the model
    // ------------------------------------------------------------------------
    always @(posedge clk_i)
    begin : scoreboard
        slot_rec_t h0;
        slot_rec_t h1;
        logic      pushing;
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
            abort_run("timeout: test did not finish");
        if (!rst_i)
        begin
            h0 = '0;
            h1 = '0;
            if (exp0_q.size() != 0)
            begin
                h0 = exp0_q[0];
                h1 = exp1_q[0];
            end
            check_slot(0, {slot0_instr_o, slot0_pc_o, slot0_fault_fetch_o,
                           slot0_fault_page_o, slot0_valid_o, slot0_invalid_o,
                           slot0_exec_o, slot0_lsu_o, slot0_branch_o, slot0_mul_o,
                           slot0_div_o, slot0_csr_o, slot0_rd_valid_o}, h0);
            check_slot(1, {slot1_instr_o, slot1_pc_o, slot1_fault_fetch_o,
                           slot1_fault_page_o, slot1_valid_o, slot1_invalid_o,
                           slot1_exec_o, slot1_lsu_o, slot1_branch_o, slot1_mul_o,
                           slot1_div_o, slot1_csr_o, slot1_rd_valid_o}, h1);
            compare_value("fetch_accept_o", fetch_accept_o, exp0_q.size() < FIFO_DEPTH);

            pushing      = fetch_valid_i && (exp0_q.size() < FIFO_DEPTH);
            bundle_taken = pushing || !fetch_valid_i || branch_request_i;
            if (branch_request_i)
            begin
                exp0_q.delete();
                exp1_q.delete();
            end
            else
            begin
                if (exp0_q.size() != 0)
                begin
                    h0.valid = h0.valid && !slot0_accept_i;
                    h1.valid = h1.valid && !slot1_accept_i;
                    if (!h0.valid && !h1.valid)
                    begin
                        void'(exp0_q.pop_front());
                        void'(exp1_q.pop_front());
                    end
                    else
                    begin
                        exp0_q[0] = h0;
                        exp1_q[0] = h1;
                    end
                end
                if (pushing)
                begin
                    exp0_q.push_back(expect_slot(fetch_instr_i[31:0], 3'b000, 1'b1));
                    exp1_q.push_back(expect_slot(fetch_instr_i[63:32],
                                                 fetch_decode_pkg::SLOT1_PC_OFFSET,
                                                 !fetch_pred_branch_i));
                    push_count++;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------------------
    initial
    begin
        void'($urandom(76437));
        rst_i               = 1'b1;
        fetch_valid_i       = 1'b0;
        fetch_instr_i       = '0;
        fetch_pc_i          = '0;
        fetch_pred_branch_i = 1'b0;
        fetch_fault_fetch_i = 1'b0;
        fetch_fault_page_i  = 1'b0;
        slot0_accept_i      = 1'b0;
        slot1_accept_i      = 1'b0;
        branch_request_i    = 1'b0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        while (push_count < N_BUNDLES)
        begin
            @(negedge clk_i);
            drive_random();
        end

        // Drain with both slots always accepting
        @(negedge clk_i);
        fetch_valid_i    = 1'b0;
        branch_request_i = 1'b0;
        slot0_accept_i   = 1'b1;
        slot1_accept_i   = 1'b1;
        while (exp0_q.size() != 0)
            @(negedge clk_i);

        if (slot0_valid_o || slot1_valid_o || !fetch_accept_o)
            abort_run("decode stage is not idle after draining");
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

//--- files.f
design/fetch_decode_pkg.sv
design/issue_slot_if.sv
design/fetch_fifo.sv
design/instr_decoder.sv
design/fetch_decode.sv
+incdir+verification
verification/fetch_decode_tb.sv
